//--- source/cache_pkg.sv
`default_nettype none

package cache_pkg;

    // Processor and memory geometry
    localparam int addr_width       = 16;
    localparam int data_width       = 16;
    localparam int tag_width        = 5;
    localparam int index_width      = 8;
    localparam int words_per_line   = 4;
    localparam int offset_width     = addr_width - tag_width - index_width;
    localparam int word_sel_width   = $clog2(words_per_line);

    // Main memory timing
    localparam int bank_count       = 4;
    localparam int bank_busy_cycles = 4;
    localparam int mem_read_latency = 2;

    typedef struct packed {
        logic [tag_width-1:0]    tag;
        logic [index_width-1:0]  index;
        logic [offset_width-1:0] offset;    // Bit 0 is the byte lane, always 0
    } cache_addr_t;

    typedef struct packed {
        logic                  rd;
        logic                  wr;
        logic [addr_width-1:0] addr;
        logic [data_width-1:0] wdata;
    } mem_req_t;

    typedef struct packed {
        logic                      rvalid;
        logic [data_width-1:0]     rdata;
        logic [word_sel_width-1:0] rword;  // Word within line of returned read
        logic                      stall;
        logic [bank_count-1:0]     busy;
    } mem_rsp_t;

    typedef struct packed {
        logic                      en;
        logic [index_width-1:0]    index;
        logic [word_sel_width-1:0] word;   // Also selects the word read back
        logic [data_width-1:0]     wdata;
        logic                      set_tag;
        logic [tag_width-1:0]      tag;
        logic                      set_valid;
        logic                      dirty;  // Value loaded when mark_dirty
        logic                      mark_dirty;
    } line_wr_t;

    typedef enum logic [2:0] {
        s_idle,
        s_check_dirty,
        s_writeback,
        s_wb_drain,
        s_fill_issue,
        s_fill_wait,
        s_read_done,
        s_write_alloc
    } ctrl_state_t;

endpackage

`default_nettype wire

//--- source/cache_array.sv
`timescale 1ns/1ns
`default_nettype none

module cache_array import cache_pkg::*; (
    input  wire logic                  clk,
    input  wire logic                  rst,
    input  wire cache_addr_t           addr,
    input  wire line_wr_t              line_wr,
    output logic                       lookup_hit,
    output logic [tag_width-1:0]       lookup_tag,
    output logic                       lookup_dirty,
    output logic [data_width-1:0]      lookup_word
);

    localparam int line_count = 2 ** index_width;
    localparam int word_count = line_count * words_per_line;

    logic [tag_width-1:0]  tag_mem  [line_count];
    logic [data_width-1:0] data_mem [word_count];
    logic [line_count-1:0] valid;
    logic [line_count-1:0] dirty;

    logic [index_width+word_sel_width-1:0] rd_word_addr;
    logic [index_width+word_sel_width-1:0] wr_word_addr;
    logic                                  line_valid;

    // Data RAM has a single word address, shared by lookups and writes
    assign rd_word_addr = {addr.index, line_wr.word};
    assign wr_word_addr = {line_wr.index, line_wr.word};

    assign line_valid   = valid[addr.index];
    assign lookup_tag   = tag_mem[addr.index];
    assign lookup_hit   = line_valid & (lookup_tag == addr.tag);
    assign lookup_dirty = line_valid & dirty[addr.index]; // Only valid lines write back
    assign lookup_word  = data_mem[rd_word_addr];

    always_ff @(posedge clk) begin
        if (rst) begin
            valid <= '0;
            dirty <= '0;
        end else if (line_wr.en) begin
            if (line_wr.set_valid) begin
                valid[line_wr.index] <= 1'b1;
            end
            if (line_wr.mark_dirty) begin
                dirty[line_wr.index] <= line_wr.dirty;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (line_wr.en) begin
            data_mem[wr_word_addr] <= line_wr.wdata;
            if (line_wr.set_tag) begin
                tag_mem[line_wr.index] <= line_wr.tag;
            end
        end
    end

endmodule

`default_nettype wire

//--- source/banked_mem.sv
`timescale 1ns/1ns
`default_nettype none

module banked_mem import cache_pkg::*; (
    input  wire logic     clk,
    input  wire logic     rst,
    input  wire mem_req_t mem_req,
    output mem_rsp_t      mem_rsp
);

    localparam int bank_sel_width = $clog2(bank_count);
    localparam int row_width      = addr_width - 1 - bank_sel_width;
    localparam int bank_depth     = 2 ** row_width;

    logic [data_width-1:0] bank_mem [bank_count][bank_depth];
    logic [2:0]            busy_cnt [bank_count];
    logic [bank_count-1:0] busy;

    logic [bank_sel_width-1:0] bank;
    logic [row_width-1:0]      row;
    logic                      accept;

    // Read return pipeline
    logic [mem_read_latency-1:0] pipe_valid;
    logic [data_width-1:0]       pipe_data [mem_read_latency];
    logic [word_sel_width-1:0]   pipe_word [mem_read_latency];

    assign bank   = mem_req.addr[bank_sel_width:1];   // Low word bits interleave banks
    assign row    = mem_req.addr[addr_width-1:bank_sel_width+1];
    assign accept = (mem_req.rd | mem_req.wr) & ~busy[bank];

    always_comb begin
        for (int b = 0; b < bank_count; b++) begin
            busy[b] = (busy_cnt[b] != '0);
        end
    end

    assign mem_rsp.busy   = busy;
    assign mem_rsp.stall  = (mem_req.rd | mem_req.wr) & busy[bank];
    assign mem_rsp.rvalid = pipe_valid[mem_read_latency-1];
    assign mem_rsp.rdata  = pipe_data[mem_read_latency-1];
    assign mem_rsp.rword  = pipe_word[mem_read_latency-1];

    // Each word starts out as its own word index
    initial begin
        for (int b = 0; b < bank_count; b++) begin
            for (int r = 0; r < bank_depth; r++) begin
                bank_mem[b][r] = data_width'((r << bank_sel_width) | b);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pipe_valid <= '0;
            for (int b = 0; b < bank_count; b++) begin
                busy_cnt[b] <= '0;
            end
        end else begin
            pipe_valid <= {pipe_valid[mem_read_latency-2:0], accept & mem_req.rd};
            for (int b = 0; b < bank_count; b++) begin
                if (accept && bank == bank_sel_width'(b)) begin
                    busy_cnt[b] <= 3'(bank_busy_cycles);
                end else if (busy_cnt[b] != '0) begin
                    busy_cnt[b] <= busy_cnt[b] - 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept && mem_req.wr) begin
            bank_mem[bank][row] <= mem_req.wdata;
        end
        pipe_data[0] <= bank_mem[bank][row];
        pipe_word[0] <= mem_req.addr[word_sel_width:1];
        for (int s = 1; s < mem_read_latency; s++) begin
            pipe_data[s] <= pipe_data[s-1];
            pipe_word[s] <= pipe_word[s-1];
        end
    end

endmodule

`default_nettype wire

//--- source/cache_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

module cache_ctrl import cache_pkg::*; (
    input  wire logic                  clk,
    input  wire logic                  rst,
    // Processor
    input  wire logic                  rd,
    input  wire logic                  wr,
    input  wire cache_addr_t           addr,
    input  wire logic [data_width-1:0] wdata,
    // Array lookup
    input  wire logic                  lookup_hit,
    input  wire logic [tag_width-1:0]  lookup_tag,
    input  wire logic                  lookup_dirty,
    input  wire logic [data_width-1:0] lookup_word,
    // Memory
    input  wire mem_rsp_t              mem_rsp,
    output mem_req_t                   mem_req,
    output line_wr_t                   line_wr,
    output logic [data_width-1:0]      rdata,
    output logic                       done,
    output logic                       cache_hit,
    output logic                       stall
);

    ctrl_state_t               state;
    ctrl_state_t               state_next;
    logic [word_sel_width-1:0] issue_cnt;   // Next word to send to memory
    logic [word_sel_width-1:0] ret_cnt;     // Words already back from memory
    logic [tag_width-1:0]      victim_tag;
    logic [addr_width-1:0]     fill_addr;
    logic [addr_width-1:0]     wb_addr;
    logic                      req;
    logic                      issue_ok;
    logic                      fill_ret;
    logic                      last_ret;

    assign req       = rd | wr;
    assign fill_addr = {addr.tag, addr.index, issue_cnt, 1'b0};
    assign wb_addr   = {victim_tag, addr.index, issue_cnt, 1'b0};
    assign issue_ok  = (mem_req.rd | mem_req.wr) & ~mem_rsp.stall;
    assign fill_ret  = mem_rsp.rvalid & ((state == s_fill_issue) | (state == s_fill_wait));
    assign last_ret  = fill_ret & (ret_cnt == word_sel_width'(words_per_line - 1));

    assign rdata     = lookup_word;          // Array output, valid with done
    assign cache_hit = (state == s_idle) & req & lookup_hit;
    assign stall     = (state != s_idle) | (req & ~lookup_hit);

    always_comb begin
        state_next         = state;
        done               = 1'b0;
        mem_req            = '0;
        line_wr            = '0;
        line_wr.index      = addr.index;
        line_wr.word       = addr.offset[offset_width-1:1];
        line_wr.wdata      = wdata;
        line_wr.tag        = addr.tag;

        // Fill data lands whenever it shows up
        if (fill_ret) begin
            line_wr.en     = 1'b1;
            line_wr.word   = mem_rsp.rword;
            line_wr.wdata  = mem_rsp.rdata;
        end
        if (last_ret) begin                  // Line complete, install new tag
            line_wr.set_tag    = 1'b1;
            line_wr.set_valid  = 1'b1;
            line_wr.mark_dirty = 1'b1;
            line_wr.dirty      = 1'b0;
        end

        case (state)
            s_idle: begin
                if (req && lookup_hit) begin
                    done = 1'b1;
                    if (wr) begin            // Write hit goes straight in
                        line_wr.en         = 1'b1;
                        line_wr.mark_dirty = 1'b1;
                        line_wr.dirty      = 1'b1;
                    end
                end else if (req) begin
                    state_next = s_check_dirty;
                end
            end
            s_check_dirty: begin
                state_next = lookup_dirty ? s_writeback : s_fill_issue;
            end
            s_writeback: begin
                mem_req.wr    = 1'b1;
                mem_req.addr  = wb_addr;
                mem_req.wdata = lookup_word;
                line_wr.word  = issue_cnt;   // Read victim word from array
                if (issue_ok && issue_cnt == word_sel_width'(words_per_line - 1)) begin
                    state_next = s_wb_drain;
                end
            end
            s_wb_drain: begin
                if (mem_rsp.busy == '0) begin
                    state_next = s_fill_issue;
                end
            end
            s_fill_issue: begin
                mem_req.rd   = 1'b1;
                mem_req.addr = fill_addr;
                if (issue_ok && issue_cnt == word_sel_width'(words_per_line - 1)) begin
                    state_next = s_fill_wait;
                end
            end
            s_fill_wait: begin
                if (last_ret) begin
                    state_next = rd ? s_read_done : s_write_alloc;
                end
            end
            s_read_done: begin
                done       = 1'b1;
                state_next = s_idle;
            end
            s_write_alloc: begin
                line_wr.en         = 1'b1;
                line_wr.mark_dirty = 1'b1;
                line_wr.dirty      = 1'b1;
                done               = 1'b1;
                state_next         = s_idle;
            end
            default: begin
                state_next = s_idle;
            end
        endcase
    end

    // Counters wrap back to zero after a full line
    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= s_idle;
            issue_cnt <= '0;
            ret_cnt   <= '0;
        end else begin
            state <= state_next;
            if (issue_ok) begin
                issue_cnt <= issue_cnt + 1'b1;
            end
            if (fill_ret) begin
                ret_cnt <= ret_cnt + 1'b1;
            end
        end
    end

    // Tag of the line being replaced
    always_ff @(posedge clk) begin
        if (state == s_idle && req && !lookup_hit) begin
            victim_tag <= lookup_tag;
        end
    end

endmodule

`default_nettype wire

//--- source/cache_system.sv
`timescale 1ns/1ns
`default_nettype none

module cache_system import cache_pkg::*; (
    input  wire logic                  clk,
    input  wire logic                  rst,
    input  wire logic                  rd,
    input  wire logic                  wr,
    input  wire cache_addr_t           addr,
    input  wire logic [data_width-1:0] wdata,
    output logic [data_width-1:0]      rdata,
    output logic                       done,
    output logic                       cache_hit,
    output logic                       stall
);

    logic                  lookup_hit;
    logic [tag_width-1:0]  lookup_tag;
    logic                  lookup_dirty;
    logic [data_width-1:0] lookup_word;
    mem_req_t              mem_req;
    mem_rsp_t              mem_rsp;
    line_wr_t              line_wr;

    cache_ctrl u_ctrl (
        .clk, .rst,
        .rd, .wr, .addr, .wdata,
        .lookup_hit, .lookup_tag, .lookup_dirty, .lookup_word,
        .mem_rsp, .mem_req, .line_wr,
        .rdata, .done, .cache_hit, .stall
    );

    cache_array u_array (
        .clk, .rst,
        .addr, .line_wr,
        .lookup_hit, .lookup_tag, .lookup_dirty, .lookup_word
    );

    banked_mem u_mem (
        .clk, .rst,
        .mem_req, .mem_rsp
    );

endmodule

`default_nettype wire

//--- testbench/cache_system_tb.sv
`timescale 1ns/1ns
`default_nettype none

module cache_system_tb import cache_pkg::*;;

    logic                  clk;
    logic                  rst;
    logic                  rd;
    logic                  wr;
    logic [addr_width-1:0] addr;
    logic [data_width-1:0] wdata;
    logic [data_width-1:0] rdata;
    logic                  done;
    logic                  cache_hit;
    logic                  stall;

    // One entry per access, filled from the vector file
    logic [7:0]            vec_op    [$];
    logic [addr_width-1:0] vec_addr  [$];
    logic [data_width-1:0] vec_wdata [$];
    logic [data_width-1:0] vec_rdata [$];
    logic                  vec_hit   [$];

    logic [31:0] lfsr;
    int          cycle_count;
    int          cycle_limit;

    cache_system UUT (
        .clk, .rst,
        .rd, .wr, .addr, .wdata,
        .rdata, .done, .cache_hit, .stall
    );

    always #10 clk = ~clk;

    // Run limit, armed once the vectors are loaded
    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_limit != 0 && cycle_count >= cycle_limit) begin
            $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("Test failed");
            $fatal(1);
        end
    end

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        logic feedback;
        feedback = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], feedback};
    endfunction

    task automatic show_mismatch(input string test_name, input logic [15:0] expected,
                                 input logic [15:0] actual);
        $display("Fail %s: expected %h, actual %h", test_name, expected, actual);
        $display("Test failed");
    endtask

    task automatic show_error(input string what);
        $display("%s", what);
        $display("Test failed");
    endtask

    task automatic load_vectors();
        int          fd;
        int          c;
        int          fields;
        logic [15:0] f_addr;
        logic [15:0] f_wdata;
        logic [15:0] f_rdata;
        logic [15:0] f_hit;
        fd = $fopen("testbench/cache_vectors.txt", "r");
        assert (fd != 0) else begin
            show_error("Cannot open testbench/cache_vectors.txt");
            $fatal(1);
        end
        c = $fgetc(fd);
        while (c != -1) begin
            if (c == "#") begin              // Skip comment to end of line
                while (c != -1 && c != "\n") begin
                    c = $fgetc(fd);
                end
            end else if (c == "R" || c == "W") begin
                fields = $fscanf(fd, " %h %h %h %h", f_addr, f_wdata, f_rdata, f_hit);
                assert (fields == 4) else begin
                    show_error("Malformed line in the vector file");
                    $fatal(1);
                end
                vec_op.push_back(c[7:0]);
                vec_addr.push_back(f_addr);
                vec_wdata.push_back(f_wdata);
                vec_rdata.push_back(f_rdata);
                vec_hit.push_back(f_hit[0]);
            end
            if (c != -1) begin
                c = $fgetc(fd);
            end
        end
        $fclose(fd);
        assert (vec_addr.size() > 0) else begin
            show_error("The vector file holds no accesses");
            $fatal(1);
        end
    endtask

    task automatic run_access(input int i);
        string      test_name;
        logic       is_read;
        logic [1:0] gap;
        is_read   = (vec_op[i] == "R");
        test_name = $sformatf("vector %0d %s %h", i, is_read ? "read" : "write", vec_addr[i]);
        addr      = vec_addr[i];
        wdata     = vec_wdata[i];
        rd        = is_read;
        wr        = !is_read;

        // Outputs seen at each rising edge, a hit completes at the first one
        @(posedge clk);
        while (!done) begin                  // Miss in progress
            assert (stall) else begin
                show_error($sformatf("Stall is low while %s waits for done", test_name));
                $fatal(1);
            end
            @(posedge clk);
        end

        assert (cache_hit == vec_hit[i]) else begin
            show_mismatch({test_name, " cache_hit"}, 16'(vec_hit[i]), 16'(cache_hit));
            $fatal(1);
        end
        if (vec_hit[i]) begin
            assert (!stall) else begin
                show_error($sformatf("Stall is high on the hit of %s", test_name));
                $fatal(1);
            end
        end
        if (is_read) begin
            assert (rdata == vec_rdata[i]) else begin
                show_mismatch({test_name, " rdata"}, vec_rdata[i], rdata);
                $fatal(1);
            end
        end

        // Request drops half a cycle after the completing edge
        @(negedge clk);
        rd = 1'b0;
        wr = 1'b0;
        @(posedge clk);
        assert (!done) else begin
            show_error($sformatf("Done stays high after %s", test_name));
            $fatal(1);
        end
        @(negedge clk);

        lfsr   = lfsr_step(lfsr);
        gap[0] = lfsr[0];
        lfsr   = lfsr_step(lfsr);
        gap[1] = lfsr[0];
        repeat (gap) @(negedge clk);
    endtask

    initial begin
        clk         = 1'b0;
        rst         = 1'b1;
        rd          = 1'b0;
        wr          = 1'b0;
        addr        = '0;
        wdata       = '0;
        lfsr        = 32'h3452de90;
        cycle_count = 0;
        cycle_limit = 0;

        load_vectors();
        cycle_limit = vec_addr.size() * 64 + 16;  // Worst miss is well under 64 cycles

        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        @(negedge clk);
        assert (!stall && !done) else begin
            show_error("Stall or done is high after reset with no request");
            $fatal(1);
        end

        for (int i = 0; i < vec_addr.size(); i++) begin
            run_access(i);
        end

        $display("Test completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

//--- testbench/cache_vectors.txt
# op addr wdata exp_rdata exp_hit, all hex
# exp_rdata is ignored for writes; memory starts as addr >> 1
R 0040 0000 0020 0
R 0046 0000 0023 1
R 0042 0000 0021 1
W 0044 beef 0000 1
R 0044 0000 beef 1
R 0040 0000 0020 1
W 0102 1234 0000 0
R 0102 0000 1234 1
R 0100 0000 0080 1
R 0106 0000 0083 1
R 0840 0000 0420 0
R 0846 0000 0423 1
R 0044 0000 beef 0
R 0040 0000 0020 1
W 1904 a5a5 0000 0
R 1904 0000 a5a5 1
R 1900 0000 0c80 1
R 0102 0000 1234 0
R 0106 0000 0083 1
R 1904 0000 a5a5 0
R 12aa 0000 0955 0
R 12ae 0000 0957 1
R faa8 0000 7d54 0
R 12aa 0000 0955 0
R faac 0000 7d56 0
W 12ae 7777 0000 0
W 12a8 8888 0000 1
R faae 0000 7d57 0
R 12ae 0000 7777 0
R 12a8 0000 8888 1
R 12ac 0000 0956 1
R 0000 0000 0000 0
W 0006 ffff 0000 1
R fffe 0000 7fff 0
R 0006 0000 ffff 1
R fff8 0000 7ffc 1

//--- all.f
source/cache_pkg.sv
source/cache_array.sv
source/banked_mem.sv
source/cache_ctrl.sv
source/cache_system.sv
testbench/cache_system_tb.sv

//--- Bender.yml
package:
  name: cache_system

sources:
  - files:
      - source/cache_pkg.sv
      - source/cache_array.sv
      - source/banked_mem.sv
      - source/cache_ctrl.sv
      - source/cache_system.sv
  - target: test
    files:
      - testbench/cache_system_tb.sv
